// ==== slave_translator.f ====
+incdir+tests
logic/xlat_pkg.sv
logic/xlat_cmd_if.sv
logic/cmd_mapper.sv
logic/wait_timer.sv
logic/read_return.sv
logic/slave_translator.sv
tests/tb_slave_translator.sv

// ==== Makefile ====
# Verilator build and run of the slave translator testbench

VERILATOR ?= verilator
TOP       ?= tb_slave_translator
RTL_TOP   ?= slave_translator
FILELIST  ?= slave_translator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST)) tests/tb_tasks.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_tasks.svh ====
// ------------------------------
// directed tests and typed compare tasks
// included inside the testbench top
// ------------------------------

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp));
   end
endtask

task automatic check_data(input string name, input xlat_pkg::data_t got,
                          input xlat_pkg::data_t exp);
   if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
   end
endtask

task automatic check_addr(input string name, input xlat_pkg::av_addr_t got,
                          input xlat_pkg::av_addr_t exp);
   if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
   end
endtask

task automatic check_count(input string name, input xlat_pkg::av_burst_t got,
                           input xlat_pkg::av_burst_t exp);
   if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp));
   end
endtask

task automatic check_be(input string name, input xlat_pkg::be_t got, input xlat_pkg::be_t exp);
   if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp));
   end
endtask

// ------------------------------
// request driver
// ------------------------------
// holds one request from the next edge and checks each cycle until accept
task automatic run_request(input logic is_write, input xlat_pkg::uav_addr_t addr,
                           input xlat_pkg::uav_burst_t burst, input xlat_pkg::be_t be,
                           input logic first_beat, output int unsigned accept_cycle);
   int              k;
   int              end_k;
   logic            done;
   xlat_pkg::data_t wdata;
   end_k = is_write ? SETUP_WAIT + WRITE_WAIT + HOLD_WAIT : SETUP_WAIT + READ_WAIT;
   wdata = xlat_pkg::data_t'(~addr);
   k     = 0;
   done  = 1'b0;
   @(posedge clk);
   uav_address    <= addr;
   uav_burstcount <= burst;
   uav_byteenable <= be;
   uav_writedata  <= wdata;
   uav_read       <= !is_write;
   uav_write      <= is_write;
   while (!done) begin
      @(negedge clk);
      check_bit("uav_waitrequest", uav_waitrequest, k != end_k);
      check_bit("av_read", av_read, !is_write && k >= SETUP_WAIT);
      check_bit("av_write", av_write,
                is_write && k >= SETUP_WAIT && k <= SETUP_WAIT + WRITE_WAIT);
      check_bit("av_begintransfer", av_begintransfer, k == 0);
      check_bit("av_beginbursttransfer", av_beginbursttransfer, k == 0 && first_beat);
      check_bit("av_chipselect", av_chipselect, 1'b1);
      check_addr("av_address", av_address, xlat_pkg::av_addr_t'(addr >> 2));
      check_count("av_burstcount", av_burstcount, xlat_pkg::av_burst_t'(burst >> 2));
      check_be("av_byteenable", av_byteenable, be);
      check_be("av_writebyteenable", av_writebyteenable, is_write ? be : xlat_pkg::be_t'(0));
      check_data("av_writedata", av_writedata, wdata);
      if (!uav_waitrequest) begin
         done         = 1'b1;
         accept_cycle = cycle_no;
      end else if (k >= MAX_WAIT) begin
         stop_on_error("uav_waitrequest never went low for a held request");
      end
      k++;
   end
endtask

task automatic go_idle(input int cycles);
   @(posedge clk);
   uav_read  <= 1'b0;
   uav_write <= 1'b0;
   repeat (cycles) @(posedge clk);
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic reset_state();
   @(negedge clk);   // first cycle out of reset
   check_bit("uav_waitrequest", uav_waitrequest, 1'b1);
   check_bit("av_read", av_read, 1'b0);
   check_bit("av_write", av_write, 1'b0);
   check_bit("av_chipselect", av_chipselect, 1'b0);
   check_bit("uav_readdatavalid", uav_readdatavalid, 1'b0);
   check_bit("av_begintransfer", av_begintransfer, 1'b0);
   check_bit("av_beginbursttransfer", av_beginbursttransfer, 1'b0);
endtask

task automatic single_read();
   int unsigned acc;
   run_request(1'b0, 32'h0000_1237, 10'd4, 4'b1111, 1'b1, acc);   // low bits dropped
   go_idle(1);
endtask

task automatic single_write();
   int unsigned acc;
   run_request(1'b1, 32'h0000_2040, 10'd4, 4'b0110, 1'b1, acc);
   go_idle(1);
endtask

// four reads with no gap and their returns followed in a parallel branch
task automatic read_stream();
   int unsigned     acc_q[$];
   xlat_pkg::data_t exp_q[$];
   int unsigned     acc;
   int              got;
   logic            exp_valid;
   fork
      begin
         for (int i = 0; i < 4; i++) begin
            exp_q.push_back(slave_read_word(xlat_pkg::av_addr_t'(32'h0000_0c00 + i)));
            run_request(1'b0, 32'h0000_3000 + 4 * i, 10'd4, 4'b1111, 1'b1, acc);
            acc_q.push_back(acc);
         end
         go_idle(0);
      end
      begin
         got = 0;
         @(posedge clk);   // first read goes out on this edge
         while (got < 4) begin
            @(negedge clk);
            exp_valid = acc_q.size() > 0 && cycle_no == acc_q[0] + READ_LATENCY;
            check_bit("uav_readdatavalid", uav_readdatavalid, exp_valid);
            check_bit("av_chipselect", av_chipselect, 1'b1);   // up through the latency
            if (exp_valid) begin
               check_data("uav_readdata", uav_readdata, exp_q.pop_front());
               void'(acc_q.pop_front());
               got++;
            end
         end
      end
   join
   @(negedge clk);
   check_bit("av_chipselect", av_chipselect, 1'b0);
   check_bit("uav_readdatavalid", uav_readdatavalid, 1'b0);
endtask

task automatic write_burst();
   int unsigned acc;
   for (int b = 0; b < 3; b++) begin
      run_request(1'b1, 32'h0000_4000, 10'd12, 4'b1111, b == 0, acc);   // 12 symbols
   end
   go_idle(2);
endtask

`endif

// ==== tests/tb_slave_translator.sv ====
// ------------------------------
// testbench top with clock, reset, watchdog, bridge DUT and a fixed-latency slave model
// ------------------------------

`timescale 1ns/1ps

module tb_slave_translator;

   localparam int SETUP_WAIT   = 1;
   localparam int READ_WAIT    = 2;
   localparam int WRITE_WAIT   = 1;
   localparam int HOLD_WAIT    = 1;
   localparam int READ_LATENCY = 2;
   localparam int MAX_WAIT     = 16;   // beyond the longest request the counter allows

   // cycles of one request including the accept cycle
   localparam int RD_CYCLES   = SETUP_WAIT + READ_WAIT + 1;
   localparam int WR_CYCLES   = SETUP_WAIT + WRITE_WAIT + HOLD_WAIT + 1;
   localparam int TEST_CYCLES = 3 + 5 * RD_CYCLES + 4 * WR_CYCLES + READ_LATENCY + 12;

   logic                 clk;
   logic                 reset;
   xlat_pkg::uav_addr_t  uav_address;
   xlat_pkg::uav_burst_t uav_burstcount;
   xlat_pkg::be_t        uav_byteenable;
   xlat_pkg::data_t      uav_writedata;
   logic                 uav_read;
   logic                 uav_write;
   logic                 uav_waitrequest;
   logic                 uav_readdatavalid;
   xlat_pkg::data_t      uav_readdata;
   xlat_pkg::av_addr_t   av_address;
   xlat_pkg::av_burst_t  av_burstcount;
   xlat_pkg::be_t        av_byteenable;
   xlat_pkg::data_t      av_writedata;
   logic                 av_read;
   logic                 av_write;
   xlat_pkg::be_t        av_writebyteenable;
   logic                 av_begintransfer;
   logic                 av_beginbursttransfer;
   logic                 av_chipselect;
   xlat_pkg::data_t      av_readdata;

   integer               seed = 32'h3b26_cc09;
   int unsigned          cycle_no;
   xlat_pkg::data_t      slave_mem [xlat_pkg::av_addr_t];   // filled on first use
   logic                 slave_rd_pending;
   xlat_pkg::av_addr_t   slave_rd_addr;

   slave_translator #(
      .SETUP_WAIT   (SETUP_WAIT),
      .READ_WAIT    (READ_WAIT),
      .WRITE_WAIT   (WRITE_WAIT),
      .HOLD_WAIT    (HOLD_WAIT),
      .READ_LATENCY (READ_LATENCY)
   ) UUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycle_no <= cycle_no + 1;

   // ------------------------------
   // slave model
   // ------------------------------
   function automatic xlat_pkg::data_t slave_read_word(xlat_pkg::av_addr_t a);
      if (!slave_mem.exists(a)) begin
         slave_mem[a] = $random(seed) ^ xlat_pkg::data_t'(a);   // whole address folded in
      end
      return slave_mem[a];
   endfunction

   // capture stage plus output register give the latency of 2
   always @(posedge clk) begin
      slave_rd_pending <= av_read && !uav_waitrequest;
      slave_rd_addr    <= av_address;
      if (slave_rd_pending) begin
         av_readdata <= slave_read_word(slave_rd_addr);
      end
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   `include "tb_tasks.svh"

   // watchdog
   initial begin
      #((TEST_CYCLES + 50) * 10);
      $display("timeout: the tests did not finish in the expected time");
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      cycle_no         = 0;
      uav_address      = '0;
      uav_burstcount   = '0;
      uav_byteenable   = '0;
      uav_writedata    = '0;
      uav_read         = 1'b0;
      uav_write        = 1'b0;
      av_readdata      = '0;
      slave_rd_pending = 1'b0;
      slave_rd_addr    = '0;
      reset            = 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      reset_state();
      single_read();
      single_write();
      read_stream();
      write_burst();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== logic/slave_translator.sv ====
// ------------------------------
// bridge top: symbol-addressed master port to a fixed-timing slave
// ------------------------------

`timescale 1ns/1ps

module slave_translator #(
   parameter int SETUP_WAIT   = 1,
   parameter int READ_WAIT    = 2,
   parameter int WRITE_WAIT   = 1,
   parameter int HOLD_WAIT    = 1,
   parameter int READ_LATENCY = 2
) (
   input  logic                  clk,
   input  logic                  reset,

   // master side
   input  xlat_pkg::uav_addr_t   uav_address,
   input  xlat_pkg::uav_burst_t  uav_burstcount,
   input  xlat_pkg::be_t         uav_byteenable,
   input  xlat_pkg::data_t       uav_writedata,
   input  logic                  uav_read,
   input  logic                  uav_write,
   output logic                  uav_waitrequest,
   output logic                  uav_readdatavalid,
   output xlat_pkg::data_t       uav_readdata,

   // slave side
   output xlat_pkg::av_addr_t    av_address,
   output xlat_pkg::av_burst_t   av_burstcount,
   output xlat_pkg::be_t         av_byteenable,
   output xlat_pkg::data_t       av_writedata,
   output logic                  av_read,
   output logic                  av_write,
   output xlat_pkg::be_t         av_writebyteenable,
   output logic                  av_begintransfer,
   output logic                  av_beginbursttransfer,
   output logic                  av_chipselect,
   input  xlat_pkg::data_t       av_readdata
);

   logic rd_accept;
   logic reads_pending;

   xlat_cmd_if cmd_bus ();

   // ------------------------------
   // stages
   // ------------------------------
   cmd_mapper u_mapper (
      .clk            (clk),
      .reset          (reset),
      .uav_address    (uav_address),
      .uav_burstcount (uav_burstcount),
      .uav_byteenable (uav_byteenable),
      .uav_writedata  (uav_writedata),
      .uav_read       (uav_read),
      .uav_write      (uav_write),
      .cmd            (cmd_bus.mapper)
   );

   wait_timer #(
      .SETUP_WAIT (SETUP_WAIT),
      .READ_WAIT  (READ_WAIT),
      .WRITE_WAIT (WRITE_WAIT),
      .HOLD_WAIT  (HOLD_WAIT)
   ) u_timer (
      .clk                (clk),
      .reset              (reset),
      .cmd                (cmd_bus.timer),
      .reads_pending      (reads_pending),
      .uav_waitrequest    (uav_waitrequest),
      .rd_accept          (rd_accept),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_writebyteenable (av_writebyteenable),
      .av_chipselect      (av_chipselect)
   );

   read_return #(
      .READ_LATENCY (READ_LATENCY)
   ) u_return (
      .clk               (clk),
      .reset             (reset),
      .rd_accept         (rd_accept),
      .av_readdata       (av_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata),
      .reads_pending     (reads_pending)
   );

   // translated fields out to the slave
   assign av_address            = cmd_bus.address;
   assign av_burstcount         = cmd_bus.burstcount;
   assign av_byteenable         = cmd_bus.byteenable;
   assign av_writedata          = cmd_bus.writedata;
   assign av_begintransfer      = cmd_bus.begintransfer;
   assign av_beginbursttransfer = cmd_bus.beginbursttransfer;

endmodule

// ==== logic/read_return.sv ====
// ------------------------------
// third stage: fixed-latency read return from a slave with no valid of its own
// ------------------------------

`timescale 1ns/1ps

module read_return #(
   parameter int READ_LATENCY = 2    // at least 1
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              rd_accept,
   input  xlat_pkg::data_t   av_readdata,
   output logic              uav_readdatavalid,
   output xlat_pkg::data_t   uav_readdata,
   output logic              reads_pending
);

   // one bit per read in flight
   logic [READ_LATENCY-1:0] lat_pipe;

   // ------------------------------
   // latency pipeline
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lat_pipe <= '0;
      end else begin
         lat_pipe[0] <= rd_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            lat_pipe[i] <= lat_pipe[i-1];
         end
      end
   end

   assign uav_readdatavalid = lat_pipe[READ_LATENCY-1];

   // still high in the data cycle itself
   assign reads_pending = |lat_pipe;

   // slave drives data in the valid cycle
   assign uav_readdata = av_readdata;

endmodule

// ==== logic/wait_timer.sv ====
// ------------------------------
// second stage: wait-state counter, slave strobes and generated waitrequest
// ------------------------------

`timescale 1ns/1ps

module wait_timer #(
   parameter int SETUP_WAIT = 1,
   parameter int READ_WAIT  = 2,
   parameter int WRITE_WAIT = 1,
   parameter int HOLD_WAIT  = 1
) (
   input  logic              clk,
   input  logic              reset,
   xlat_cmd_if.timer         cmd,
   input  logic              reads_pending,
   output logic              uav_waitrequest,
   output logic              rd_accept,
   output logic              av_read,
   output logic              av_write,
   output xlat_pkg::be_t     av_writebyteenable,
   output logic              av_chipselect
);

   // ------------------------------
   // end counts per phase
   // ------------------------------
   localparam xlat_pkg::wait_cnt_t SETUP_END = xlat_pkg::wait_cnt_t'(SETUP_WAIT);
   localparam xlat_pkg::wait_cnt_t READ_END  = xlat_pkg::wait_cnt_t'(SETUP_WAIT + READ_WAIT);
   localparam xlat_pkg::wait_cnt_t WRITE_END = xlat_pkg::wait_cnt_t'(SETUP_WAIT + WRITE_WAIT);
   localparam xlat_pkg::wait_cnt_t HOLD_END  =
      xlat_pkg::wait_cnt_t'(SETUP_WAIT + WRITE_WAIT + HOLD_WAIT);

   xlat_pkg::wait_cnt_t wait_cnt;
   logic                request;
   logic                reset_hold;    // high for one cycle out of reset
   logic                wait_gen;
   logic                accept;

   assign request = cmd.read | cmd.write;

   // writes also wait out the data hold
   assign wait_gen        = cmd.write ? (wait_cnt != HOLD_END) : (wait_cnt != READ_END);
   assign uav_waitrequest = wait_gen | reset_hold;
   assign accept          = request & ~uav_waitrequest;
   assign cmd.accept      = accept;
   assign rd_accept       = cmd.read & accept;

   // ------------------------------
   // slave strobes
   // ------------------------------
   assign av_read  = cmd.read & (wait_cnt >= SETUP_END);
   assign av_write = cmd.write & (wait_cnt >= SETUP_END) & (wait_cnt <= WRITE_END);

   assign av_writebyteenable = {xlat_pkg::BE_W{cmd.write}} & cmd.byteenable;

   // kept up through the read latency
   assign av_chipselect = request | reads_pending;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         reset_hold <= 1'b1;
      end else begin
         reset_hold <= 1'b0;
      end
   end

   // one count per held cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt <= '0;
      end else if (accept || reset_hold || !request) begin
         wait_cnt <= '0;
      end else begin
         wait_cnt <= wait_cnt + xlat_pkg::wait_cnt_t'(1);
      end
   end

endmodule

// ==== logic/cmd_mapper.sv ====
// ------------------------------
// first stage: symbol address and count to words, plus transfer pulses
// ------------------------------

`timescale 1ns/1ps

module cmd_mapper (
   input  logic                   clk,
   input  logic                   reset,
   input  xlat_pkg::uav_addr_t    uav_address,
   input  xlat_pkg::uav_burst_t   uav_burstcount,
   input  xlat_pkg::be_t          uav_byteenable,
   input  xlat_pkg::data_t        uav_writedata,
   input  logic                   uav_read,
   input  logic                   uav_write,
   xlat_cmd_if.mapper             cmd
);

   logic                request;
   logic                begin_xfer;
   logic                in_request;    // past the first cycle of a held request
   logic                in_burst;      // write burst still has beats to go
   xlat_pkg::av_burst_t word_count;
   xlat_pkg::av_burst_t beats_left;   // beats after the current one

   assign request    = uav_read | uav_write;
   assign word_count = uav_burstcount[xlat_pkg::UAV_BURST_W-1:xlat_pkg::WORD_SHIFT];

   // ------------------------------
   // translated fields
   // ------------------------------
   assign cmd.address    = uav_address[xlat_pkg::UAV_ADDR_W-1:xlat_pkg::WORD_SHIFT];
   assign cmd.burstcount = word_count;
   assign cmd.byteenable = uav_byteenable;
   assign cmd.writedata  = uav_writedata;
   assign cmd.read       = uav_read;
   assign cmd.write      = uav_write;

   // ------------------------------
   // transfer pulses
   // ------------------------------
   assign begin_xfer             = request & ~in_request;
   assign cmd.begintransfer      = begin_xfer;
   // reads always start a burst, writes only on the first beat
   assign cmd.beginbursttransfer = uav_read ? begin_xfer : (begin_xfer & ~in_burst);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_request <= 1'b0;
      end else if (cmd.accept) begin
         in_request <= 1'b0;
      end else if (request) begin
         in_request <= 1'b1;       // still waiting
      end
   end

   // write burst beat counter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_burst   <= 1'b0;
         beats_left <= '0;
      end else if (uav_write && cmd.accept) begin
         if (!in_burst) begin
            if (word_count > xlat_pkg::av_burst_t'(1)) begin
               in_burst   <= 1'b1;
               beats_left <= word_count - xlat_pkg::av_burst_t'(1);
            end
         end else begin
            beats_left <= beats_left - xlat_pkg::av_burst_t'(1);
            if (beats_left == xlat_pkg::av_burst_t'(1)) begin
               in_burst <= 1'b0;   // last beat taken
            end
         end
      end
   end

endmodule

// ==== logic/xlat_cmd_if.sv ====
// ------------------------------
// one translated command, passed from the mapper stage to the wait timer
// ------------------------------

`timescale 1ns/1ps

interface xlat_cmd_if;

   xlat_pkg::av_addr_t  address;        // word address
   xlat_pkg::av_burst_t burstcount;     // word count
   xlat_pkg::be_t       byteenable;
   xlat_pkg::data_t     writedata;
   logic                read;
   logic                write;
   logic                begintransfer;
   logic                beginbursttransfer;

   // request completes this cycle
   logic                accept;

   modport mapper (
      output address, burstcount, byteenable, writedata,
      output read, write, begintransfer, beginbursttransfer,
      input  accept
   );

   modport timer (
      input  address, burstcount, byteenable, writedata,
      input  read, write, begintransfer, beginbursttransfer,
      output accept
   );

endinterface

// ==== logic/xlat_pkg.sv ====
// ------------------------------
// bus widths, word shift and vector types shared by every bridge stage
// reached by scoped names only
// ------------------------------

package xlat_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int UAV_ADDR_W  = 32;   // master byte address
   localparam int AV_ADDR_W   = 30;   // slave word address
   localparam int DATA_W      = 32;
   localparam int BE_W        = 4;
   localparam int WORD_SHIFT  = 2;    // log2 of symbols per word
   localparam int UAV_BURST_W = 10;   // master count, in symbols
   localparam int AV_BURST_W  = 8;    // slave count, in words

   // up to 15 wait cycles per request
   localparam int CNT_W       = 4;

   // ------------------------------
   // vector types
   // ------------------------------
   typedef logic [UAV_ADDR_W-1:0]  uav_addr_t;
   typedef logic [AV_ADDR_W-1:0]   av_addr_t;
   typedef logic [DATA_W-1:0]      data_t;
   typedef logic [BE_W-1:0]        be_t;
   typedef logic [UAV_BURST_W-1:0] uav_burst_t;
   typedef logic [AV_BURST_W-1:0]  av_burst_t;
   typedef logic [CNT_W-1:0]       wait_cnt_t;

endpackage
